// File: files.f
+incdir+testbench
design/sldu_cfg_pkg.sv
design/sldu_insn_pkg.sv
design/sldu_insn_queue.sv
design/sldu_slide_engine.sv
design/sldu_result_queue.sv
design/sldu_top.sv
testbench/tb_sldu.sv

// File: testbench/tb_sldu_model.svh
/*
  Galois LFSR for random stimulus
  Source memory model, byte mask helper, expected result words
  and expected operand reads
*/

`ifndef TB_SLDU_MODEL_SVH
`define TB_SLDU_MODEL_SVH

localparam int unsigned WordBytes = LaneCount * 8;
// Source words reachable by the stimulus
localparam int unsigned SrcWords  = 64;

// One result word as seen on the result port
typedef struct packed {
  sldu_insn_pkg::result_hdr_t hdr;
  logic [8*WordBytes-1:0]     data;
  logic [WordBytes-1:0]       be;
} word_t;

logic [31:0]            lfsr_state = 32'ha890;
logic [8*WordBytes-1:0] src_mem [SrcWords];
// Expected result words in completion order
word_t                  exp_q[$];
// Expected operand addresses, one per source word read
sldu_cfg_pkg::vaddr_t   src_q[$];

// One LFSR step per bit, bit 0 is the one taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
  end
  return r;
endfunction

function automatic void fill_src_mem();
  for (int a = 0; a < SrcWords; a++) begin
    for (int b = 0; b < WordBytes; b++) begin
      src_mem[a][8*b +: 8] = 8'(rand_bits(8));
    end
  end
endfunction

// Linear layout, byte k in word k / WordBytes
function automatic logic [7:0] src_byte(input sldu_cfg_pkg::vaddr_t base, input int k);
  int a;
  a = int'(base) + k / WordBytes;
  return src_mem[a % SrcWords][8*(k % WordBytes) +: 8];
endfunction

// Bit mask from byte enables
function automatic logic [8*WordBytes-1:0] be_mask(input logic [WordBytes-1:0] be);
  logic [8*WordBytes-1:0] m;
  for (int b = 0; b < WordBytes; b++) begin
    m[8*b +: 8] = {8{be[b]}};
  end
  return m;
endfunction

// Expected destination words of one instruction from the slide rule
function automatic void expect_slide_words(input sldu_insn_pkg::slide_insn_t insn);
  int    len;
  int    off;
  int    wr_lo;
  int    rd_lo;
  int    rd_hi;
  int    d;
  word_t w;
  len   = int'(insn.vl) << insn.vsew;
  off   = int'(insn.stride) << insn.vsew;
  // Slide up leaves the bytes below the offset alone
  wr_lo = (insn.op == sldu_insn_pkg::SLIDE_UP) ? off : 0;
  for (int wd = wr_lo / WordBytes; wd <= (len - 1) / WordBytes; wd++) begin
    w          = '0;
    w.hdr.id   = insn.id;
    w.hdr.addr = insn.vd + sldu_cfg_pkg::vaddr_t'(wd);
    w.hdr.last = (wd == (len - 1) / WordBytes);
    for (int b = 0; b < WordBytes; b++) begin
      d = wd * WordBytes + b;
      if (d >= wr_lo && d < len) begin
        w.be[b] = 1'b1;
        if (insn.op == sldu_insn_pkg::SLIDE_UP) begin
          w.data[8*b +: 8] = src_byte(insn.vs2, d - off);
        end else begin
          w.data[8*b +: 8] = src_byte(insn.vs2, d + off);
        end
      end
    end
    exp_q.push_back(w);
  end
  // Source bytes taken, each word holding one of them is read once
  if (insn.op == sldu_insn_pkg::SLIDE_UP) begin
    rd_lo = 0;
    rd_hi = len - off - 1;
  end else begin
    rd_lo = off;
    rd_hi = off + len - 1;
  end
  for (int ws = rd_lo / WordBytes; ws <= rd_hi / WordBytes; ws++) begin
    src_q.push_back(insn.vs2 + sldu_cfg_pkg::vaddr_t'(ws));
  end
endfunction

`endif

// File: testbench/tb_sldu.sv
/*
  Testbench of the slide unit
  Clock, reset, instruction stimulus, operand responder, result back-pressure
  Compare process with one check task, and a watchdog
*/

`timescale 1ns/10ps

module tb_sldu;

  localparam int unsigned LaneCount = 4;
  localparam int unsigned RandInsns = 40;
  // Eight directed, three back to back, the rest random
  localparam int unsigned NumInsns  = RandInsns + 11;

  logic                                 clk;
  logic                                 rst_n;
  sldu_insn_pkg::slide_insn_t           insn;
  logic                                 insn_valid;
  logic                                 insn_ready;
  sldu_cfg_pkg::vaddr_t                 operand_addr;
  sldu_cfg_pkg::elen_t  [LaneCount-1:0] operand;
  logic                                 operand_valid;
  logic                                 operand_ready;
  sldu_insn_pkg::result_hdr_t           result_hdr;
  sldu_cfg_pkg::elen_t  [LaneCount-1:0] result_data;
  sldu_cfg_pkg::strb_t  [LaneCount-1:0] result_be;
  logic                                 result_valid;
  logic                                 result_ready;
  sldu_insn_pkg::slide_done_t           done;
  logic                                 done_valid;

  `include "tb_sldu_model.svh"

  sldu_cfg_pkg::id_t done_q[$];
  sldu_cfg_pkg::id_t next_id      = '0;
  int                err_cnt      = 0;
  int                chk_cnt      = 0;
  // Holds the result port stalled
  logic              stall_result = 1'b0;
  logic              prev_stall   = 1'b0;
  logic              prev_last_hs = 1'b0;
  word_t             prev_word;

  sldu_top #(
    .LaneCount (LaneCount)
  ) UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .insn_i          (insn),
    .insn_valid_i    (insn_valid),
    .insn_ready_o    (insn_ready),
    .operand_addr_o  (operand_addr),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_hdr_o    (result_hdr),
    .result_data_o   (result_data),
    .result_be_o     (result_be),
    .result_valid_o  (result_valid),
    .result_ready_i  (result_ready),
    .done_o          (done),
    .done_valid_o    (done_valid)
  );

  task automatic check_equal(input string what, input logic [511:0] got,
                             input logic [511:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic sldu_insn_pkg::slide_insn_t make_insn(
    input sldu_insn_pkg::slide_op_e op, input sldu_cfg_pkg::vsew_e ew,
    input int vl, input int stride, input int vs2, input int vd);
    sldu_insn_pkg::slide_insn_t i;
    i.id     = next_id;
    next_id  = next_id + 1'b1;
    i.op     = op;
    i.vsew   = ew;
    i.vl     = sldu_cfg_pkg::vlen_t'(vl);
    i.stride = sldu_cfg_pkg::vlen_t'(stride);
    i.vs2    = sldu_cfg_pkg::vaddr_t'(vs2);
    i.vd     = sldu_cfg_pkg::vaddr_t'(vd);
    return i;
  endfunction

  // Drives one instruction until accepted, returns the cycles spent waiting
  task automatic send_insn(input sldu_insn_pkg::slide_insn_t i, output int waited);
    waited = 0;
    @(posedge clk);
    #1;
    insn       = i;
    insn_valid = 1'b1;
    @(negedge clk);
    while (!insn_ready) begin
      waited++;
      @(negedge clk);
    end
    // Handshake completes on the coming edge
    expect_slide_words(i);
    done_q.push_back(i.id);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, operand responder and result back-pressure
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Address is registered, so the word read here stays right for the cycle
  always @(posedge clk) begin
    #1;
    operand_valid = (rand_bits(2) != 2'b00);
    operand       = src_mem[operand_addr % SrcWords];
    result_ready  = stall_result ? 1'b0 : (rand_bits(2) != 2'b00);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  // Sampled mid-cycle, a handshake seen here completes on the next edge
  always @(negedge clk) begin : compare
    word_t got;
    word_t w;
    if (rst_n) begin
      got.hdr  = result_hdr;
      got.data = result_data;
      got.be   = result_be;
      // Done comes exactly one cycle after a last word left
      check_equal("done valid", done_valid, prev_last_hs);
      if (done_valid) begin
        if (done_q.size() == 0) begin
          err_cnt++;
          $display("Done pulse at %0d ns with no instruction outstanding", $time);
        end else begin
          check_equal("done id", done.id, done_q.pop_front());
        end
      end
      // Stalled word must not move
      if (prev_stall) begin
        check_equal("result valid held", result_valid, 1'b1);
        check_equal("result word held", got, prev_word);
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Result word at %0d ns with no word expected", $time);
        end else begin
          w = exp_q.pop_front();
          check_equal("result header", result_hdr, w.hdr);
          check_equal("byte enables", result_be, w.be);
          check_equal("result data", result_data & be_mask(w.be), w.data);
        end
      end
      // Each consumed source word is read once, in order
      if (operand_valid && operand_ready) begin
        if (src_q.size() == 0) begin
          err_cnt++;
          $display("Operand consumed at %0d ns with no read expected", $time);
        end else begin
          check_equal("operand address", operand_addr, src_q.pop_front());
        end
      end
      prev_stall   = result_valid && !result_ready;
      prev_word    = got;
      prev_last_hs = result_valid && result_ready && result_hdr.last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int                         waited;
    int                         vl;
    int                         stride;
    logic                       gap;
    sldu_insn_pkg::slide_op_e   op;
    sldu_cfg_pkg::vsew_e        ew;
    sldu_insn_pkg::slide_insn_t c;
    rst_n         = 1'b0;
    insn          = '0;
    insn_valid    = 1'b0;
    operand       = '0;
    operand_valid = 1'b0;
    result_ready  = 1'b0;
    fill_src_mem();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_equal("result valid after reset", result_valid, 1'b0);
    check_equal("done valid after reset", done_valid, 1'b0);
    check_equal("operand ready after reset", operand_ready, 1'b0);
    check_equal("insn ready after reset", insn_ready, 1'b1);

    // Each element width, up then down, offsets across word boundaries
    for (int e = 0; e < 4; e++) begin
      ew = sldu_cfg_pkg::vsew_e'(e);
      send_insn(make_insn(sldu_insn_pkg::SLIDE_UP, ew, 24, 5, 4 * e, 100 + 16 * e), waited);
      send_insn(make_insn(sldu_insn_pkg::SLIDE_DOWN, ew, 20, 7, 3 * e, 400 + 16 * e), waited);
    end
    @(posedge clk);
    #1;
    insn_valid = 1'b0;
    while (exp_q.size() != 0 || done_q.size() != 0) @(negedge clk);

    // Back to back with the result port stalled, the third must wait
    stall_result = 1'b1;
    send_insn(make_insn(sldu_insn_pkg::SLIDE_DOWN, sldu_cfg_pkg::EW64, 16, 0, 0, 200), waited);
    check_equal("first insn wait", waited, 0);
    send_insn(make_insn(sldu_insn_pkg::SLIDE_UP, sldu_cfg_pkg::EW8, 40, 3, 8, 300), waited);
    check_equal("second insn wait", waited, 0);
    c = make_insn(sldu_insn_pkg::SLIDE_DOWN, sldu_cfg_pkg::EW32, 24, 9, 16, 500);
    @(posedge clk);
    #1;
    insn = c;
    repeat (20) begin
      @(negedge clk);
      check_equal("insn ready while stalled", insn_ready, 1'b0);
    end
    stall_result = 1'b0;
    while (!insn_ready) @(negedge clk);
    expect_slide_words(c);
    done_q.push_back(c.id);

    // Random instructions, up keeps the offset inside the vector
    for (int n = 0; n < RandInsns; n++) begin
      ew = sldu_cfg_pkg::vsew_e'(rand_bits(2));
      op = sldu_insn_pkg::slide_op_e'(rand_bits(1));
      vl = int'(rand_bits(5)) + 1;
      if (op == sldu_insn_pkg::SLIDE_UP) begin
        stride = int'(rand_bits(5)) % vl;
      end else begin
        stride = int'(rand_bits(5));
      end
      send_insn(make_insn(op, ew, vl, stride, rand_bits(5), rand_bits(12)), waited);
      gap = (rand_bits(2) == 2'b00);
      if (gap) begin
        @(posedge clk);
        #1;
        insn_valid = 1'b0;
        // Next draw mid-cycle, away from the responder
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    insn_valid = 1'b0;
    while (exp_q.size() != 0 || done_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    check_equal("operand reads left", src_q.size(), 0);

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Budget of 200 cycles per instruction after reset
  initial begin : watchdog
    repeat (16 + NumInsns * 200) @(posedge clk);
    $display("Timeout: results still outstanding after %0d cycles", 16 + NumInsns * 200);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: design/sldu_top.sv
/*
  Slide unit top level
  Instruction queue, slide engine and result queue
*/

`timescale 1ns/10ps

module sldu_top #(
  parameter int unsigned LaneCount        = sldu_cfg_pkg::DefLaneCount,
  parameter int unsigned InsnQueueDepth   = sldu_cfg_pkg::DefInsnQueueDepth,
  parameter int unsigned ResultQueueDepth = sldu_cfg_pkg::DefResultQueueDepth
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Instruction port
  input  sldu_insn_pkg::slide_insn_t           insn_i,
  input  logic                                 insn_valid_i,
  output logic                                 insn_ready_o,
  // Operand port
  output sldu_cfg_pkg::vaddr_t                 operand_addr_o,
  input  sldu_cfg_pkg::elen_t  [LaneCount-1:0] operand_i,
  input  logic                                 operand_valid_i,
  output logic                                 operand_ready_o,
  // Result port
  output sldu_insn_pkg::result_hdr_t           result_hdr_o,
  output sldu_cfg_pkg::elen_t  [LaneCount-1:0] result_data_o,
  output sldu_cfg_pkg::strb_t  [LaneCount-1:0] result_be_o,
  output logic                                 result_valid_o,
  input  logic                                 result_ready_i,
  // Done response
  output sldu_insn_pkg::slide_done_t           done_o,
  output logic                                 done_valid_o
);

  // Queue head towards the engine
  sldu_insn_pkg::slide_insn_t           issue;
  logic                                 issue_valid;
  logic                                 issue_ready;

  // Engine towards the result queue
  sldu_insn_pkg::result_hdr_t           push_hdr;
  sldu_cfg_pkg::elen_t  [LaneCount-1:0] push_data;
  sldu_cfg_pkg::strb_t  [LaneCount-1:0] push_be;
  logic                                 push_valid;
  logic                                 push_ready;

  sldu_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready)
  );

  sldu_slide_engine #(
    .LaneCount (LaneCount)
  ) u_slide_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (issue),
    .insn_valid_i    (issue_valid),
    .insn_ready_o    (issue_ready),
    .operand_addr_o  (operand_addr_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .push_hdr_o      (push_hdr),
    .push_data_o     (push_data),
    .push_be_o       (push_be),
    .push_valid_o    (push_valid),
    .push_ready_i    (push_ready)
  );

  sldu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth),
    .LaneCount        (LaneCount)
  ) u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_hdr_i     (push_hdr),
    .push_data_i    (push_data),
    .push_be_i      (push_be),
    .push_valid_i   (push_valid),
    .push_ready_o   (push_ready),
    .result_hdr_o   (result_hdr_o),
    .result_data_o  (result_data_o),
    .result_be_o    (result_be_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .done_o         (done_o),
    .done_valid_o   (done_valid_o)
  );

endmodule

// File: design/sldu_result_queue.sv
/*
  Result queue of the slide unit
  FIFO of destination words with header and byte enables
  Raises the done response after the last word of an instruction leaves
*/

`timescale 1ns/10ps

module sldu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned LaneCount        = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Words from the engine
  input  sldu_insn_pkg::result_hdr_t           push_hdr_i,
  input  sldu_cfg_pkg::elen_t  [LaneCount-1:0] push_data_i,
  input  sldu_cfg_pkg::strb_t  [LaneCount-1:0] push_be_i,
  input  logic                                 push_valid_i,
  output logic                                 push_ready_o,
  // Result port
  output sldu_insn_pkg::result_hdr_t           result_hdr_o,
  output sldu_cfg_pkg::elen_t  [LaneCount-1:0] result_data_o,
  output sldu_cfg_pkg::strb_t  [LaneCount-1:0] result_be_o,
  output logic                                 result_valid_o,
  input  logic                                 result_ready_i,
  // Completion
  output sldu_insn_pkg::slide_done_t           done_o,
  output logic                                 done_valid_o
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  // One stored word
  typedef struct packed {
    sldu_insn_pkg::result_hdr_t           hdr;
    sldu_cfg_pkg::elen_t  [LaneCount-1:0] data;
    sldu_cfg_pkg::strb_t  [LaneCount-1:0] be;
  } entry_t;

  entry_t [ResultQueueDepth-1:0] mem_q;
  entry_t                        head;

  logic [PtrW-1:0] wr_pnt_q;
  logic [PtrW-1:0] rd_pnt_q;
  logic [CntW-1:0] cnt_q;

  logic push;
  logic pop;

  assign push_ready_o   = (cnt_q != CntW'(ResultQueueDepth));
  // Output straight from storage, so it holds while stalled
  assign result_valid_o = (cnt_q != '0);
  assign head           = mem_q[rd_pnt_q];
  assign result_hdr_o   = head.hdr;
  assign result_data_o  = head.data;
  assign result_be_o    = head.be;

  assign push = push_valid_i & push_ready_o;
  assign pop  = result_valid_o & result_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= '{hdr: push_hdr_i, data: push_data_i, be: push_be_i};
    end
    // Id of the word that leaves, reported next cycle
    if (pop) begin
      done_o.id <= head.hdr.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q     <= '0;
      rd_pnt_q     <= '0;
      cnt_q        <= '0;
      done_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_pnt_q <= (wr_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
      // One-cycle pulse per finished instruction
      done_valid_o <= pop & head.hdr.last;
    end
  end

endmodule

// File: design/sldu_slide_engine.sv
/*
  Slide engine
  Reads source words, moves bytes by the slide offset and assembles
  destination words with byte enables for the result queue
*/

`timescale 1ns/10ps

module sldu_slide_engine #(
  parameter int unsigned LaneCount = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Head instruction, released by insn_ready_o
  input  sldu_insn_pkg::slide_insn_t               insn_i,
  input  logic                                     insn_valid_i,
  output logic                                     insn_ready_o,
  // Operand read
  output sldu_cfg_pkg::vaddr_t                     operand_addr_o,
  input  sldu_cfg_pkg::elen_t  [LaneCount-1:0]     operand_i,
  input  logic                                     operand_valid_i,
  output logic                                     operand_ready_o,
  // Destination words
  output sldu_insn_pkg::result_hdr_t               push_hdr_o,
  output sldu_cfg_pkg::elen_t  [LaneCount-1:0]     push_data_o,
  output sldu_cfg_pkg::strb_t  [LaneCount-1:0]     push_be_o,
  output logic                                     push_valid_o,
  input  logic                                     push_ready_i
);

  localparam int unsigned WordBytes = LaneCount * 8;
  localparam int unsigned OffW      = $clog2(WordBytes);
  // Byte pointers reach WordBytes itself
  localparam int unsigned PntW      = OffW + 1;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e                 state_q, state_d;
  logic [PntW-1:0]        in_pnt_q, in_pnt_d;
  logic [PntW-1:0]        out_pnt_q, out_pnt_d;
  sldu_cfg_pkg::vlen_t    remain_q, remain_d;
  sldu_cfg_pkg::vaddr_t   src_word_q, src_word_d;
  sldu_cfg_pkg::vaddr_t   dst_word_q, dst_word_d;
  // Word under assembly
  logic [8*WordBytes-1:0] asm_data_q, asm_data_d;
  logic [WordBytes-1:0]   asm_be_q, asm_be_d;

  // Start values of a new instruction
  sldu_cfg_pkg::vlen_t    len_bytes, off_bytes;
  sldu_cfg_pkg::vlen_t    in_start, out_start, start_cnt;

  // Current step
  logic [8*WordBytes-1:0] op_flat, aligned, step_data;
  logic [WordBytes-1:0]   step_be;
  sldu_cfg_pkg::vlen_t    in_room, out_room, step_cnt;
  logic                   in_used, out_full, insn_last, want_push, step;

  ////////////////////////////////////////////////////////////////////////////
  // Start of an instruction
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    len_bytes = insn_i.vl << insn_i.vsew;
    off_bytes = insn_i.stride << insn_i.vsew;
    if (insn_i.op == sldu_insn_pkg::SLIDE_UP) begin
      // Read from byte 0, write from the offset
      in_start  = '0;
      out_start = off_bytes;
      start_cnt = (off_bytes < len_bytes) ? len_bytes - off_bytes : '0;
    end else begin
      // Read from the offset, write from byte 0
      in_start  = off_bytes;
      out_start = '0;
      start_cnt = len_bytes;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte move
  ////////////////////////////////////////////////////////////////////////////

  assign op_flat  = operand_i;
  assign in_room  = sldu_cfg_pkg::vlen_t'(WordBytes) - sldu_cfg_pkg::vlen_t'(in_pnt_q);
  assign out_room = sldu_cfg_pkg::vlen_t'(WordBytes) - sldu_cfg_pkg::vlen_t'(out_pnt_q);

  always_comb begin
    // Smallest of input room, output room and bytes left
    step_cnt = (in_room < out_room) ? in_room : out_room;
    if (remain_q < step_cnt) begin
      step_cnt = remain_q;
    end
    // Source byte at in_pnt lands on destination byte out_pnt
    aligned   = (op_flat >> (8 * in_pnt_q)) << (8 * out_pnt_q);
    step_data = asm_data_q;
    step_be   = asm_be_q;
    for (int b = 0; b < WordBytes; b++) begin
      if (b >= out_pnt_q && b < out_pnt_q + step_cnt) begin
        step_data[8*b +: 8] = aligned[8*b +: 8];
        step_be[b]          = 1'b1;
      end
    end
  end

  assign in_used   = (step_cnt == in_room);
  assign out_full  = (step_cnt == out_room);
  assign insn_last = (step_cnt == remain_q);
  assign want_push = out_full | insn_last;

  // A step needs an operand, and room downstream when it pushes
  assign push_valid_o    = (state_q == RUN) & operand_valid_i & want_push;
  assign step            = (state_q == RUN) & operand_valid_i & (~want_push | push_ready_i);
  assign operand_ready_o = step & (in_used | insn_last);
  assign insn_ready_o    = step & insn_last;

  assign operand_addr_o  = src_word_q;
  assign push_hdr_o.id   = insn_i.id;
  assign push_hdr_o.addr = dst_word_q;
  assign push_hdr_o.last = insn_last;
  assign push_data_o     = step_data;
  assign push_be_o       = step_be;

  ////////////////////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    in_pnt_d   = in_pnt_q;
    out_pnt_d  = out_pnt_q;
    remain_d   = remain_q;
    src_word_d = src_word_q;
    dst_word_d = dst_word_q;
    asm_data_d = asm_data_q;
    asm_be_d   = asm_be_q;
    if (state_q == IDLE) begin
      if (insn_valid_i) begin
        state_d    = RUN;
        in_pnt_d   = {1'b0, in_start[OffW-1:0]};
        out_pnt_d  = {1'b0, out_start[OffW-1:0]};
        remain_d   = start_cnt;
        src_word_d = insn_i.vs2 + sldu_cfg_pkg::vaddr_t'(in_start >> OffW);
        dst_word_d = insn_i.vd + sldu_cfg_pkg::vaddr_t'(out_start >> OffW);
        asm_be_d   = '0;
      end
    end else if (step) begin
      remain_d = remain_q - step_cnt;
      // Input word used up, fetch the next one
      if (in_used) begin
        in_pnt_d   = '0;
        src_word_d = src_word_q + 1'b1;
      end else begin
        in_pnt_d = in_pnt_q + step_cnt[PntW-1:0];
      end
      // Word pushed, start a fresh one
      if (want_push) begin
        out_pnt_d  = '0;
        dst_word_d = dst_word_q + 1'b1;
        asm_be_d   = '0;
      end else begin
        out_pnt_d  = out_pnt_q + step_cnt[PntW-1:0];
        asm_data_d = step_data;
        asm_be_d   = step_be;
      end
      if (insn_last) begin
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    asm_data_q <= asm_data_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      in_pnt_q   <= '0;
      out_pnt_q  <= '0;
      remain_q   <= '0;
      src_word_q <= '0;
      dst_word_q <= '0;
      asm_be_q   <= '0;
    end else begin
      state_q    <= state_d;
      in_pnt_q   <= in_pnt_d;
      out_pnt_q  <= out_pnt_d;
      remain_q   <= remain_d;
      src_word_q <= src_word_d;
      dst_word_q <= dst_word_d;
      asm_be_q   <= asm_be_d;
    end
  end

endmodule

// File: design/sldu_insn_queue.sv
/*
  Instruction queue of the slide unit
  Circular buffer with accept and issue pointers
  Head entry is held until the engine finishes it
*/

`timescale 1ns/10ps

module sldu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Incoming instructions
  input  sldu_insn_pkg::slide_insn_t insn_i,
  input  logic                       insn_valid_i,
  output logic                       insn_ready_o,
  // Oldest instruction towards the engine
  output sldu_insn_pkg::slide_insn_t issue_o,
  output logic                       issue_valid_o,
  input  logic                       issue_ready_i
);

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  // Storage, payload only
  sldu_insn_pkg::slide_insn_t [InsnQueueDepth-1:0] mem_q;

  logic [PtrW-1:0] accept_pnt_q;
  logic [PtrW-1:0] issue_pnt_q;
  logic [CntW-1:0] cnt_q;

  logic accept;
  logic issue;

  // Room left as long as the count is below the depth
  assign insn_ready_o  = (cnt_q != CntW'(InsnQueueDepth));
  assign issue_valid_o = (cnt_q != '0);
  assign issue_o       = mem_q[issue_pnt_q];

  assign accept = insn_valid_i & insn_ready_o;
  // Engine ready marks the end of the head instruction
  assign issue  = issue_valid_o & issue_ready_i;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
    end else begin
      // Wrap both pointers at the depth
      if (accept) begin
        if (accept_pnt_q == PtrW'(InsnQueueDepth - 1)) begin
          accept_pnt_q <= '0;
        end else begin
          accept_pnt_q <= accept_pnt_q + 1'b1;
        end
      end
      if (issue) begin
        if (issue_pnt_q == PtrW'(InsnQueueDepth - 1)) begin
          issue_pnt_q <= '0;
        end else begin
          issue_pnt_q <= issue_pnt_q + 1'b1;
        end
      end
      // Simultaneous accept and issue keep the count
      cnt_q <= cnt_q + CntW'(accept) - CntW'(issue);
    end
  end

endmodule

// File: design/sldu_insn_pkg.sv
/*
  Slide operation encoding
  Instruction, result word header and done response structs
*/

package sldu_insn_pkg;

  // Slide direction
  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    sldu_cfg_pkg::id_t    id;
    slide_op_e            op;
    sldu_cfg_pkg::vsew_e  vsew;
    // Element count
    sldu_cfg_pkg::vlen_t  vl;
    // Slide offset in elements
    sldu_cfg_pkg::vlen_t  stride;
    // Source and destination base word addresses
    sldu_cfg_pkg::vaddr_t vs2;
    sldu_cfg_pkg::vaddr_t vd;
  } slide_insn_t;

  ////////////////////////////////////////////////////////////////////////////
  // Result side
  ////////////////////////////////////////////////////////////////////////////

  // Travels with every destination word
  typedef struct packed {
    sldu_cfg_pkg::id_t    id;
    sldu_cfg_pkg::vaddr_t addr;
    // Set on the final word of an instruction
    logic                 last;
  } result_hdr_t;

  // Completion report
  typedef struct packed {
    sldu_cfg_pkg::id_t id;
  } slide_done_t;

endpackage

// File: design/sldu_cfg_pkg.sv
/*
  Datapath and register file sizes of the slide unit
  Scalar types for lane data, byte enables, addresses and ids
  Default lane count and queue depths
*/

package sldu_cfg_pkg;

  // One 64-bit datum of a lane
  typedef logic [63:0] elen_t;
  // Byte enables of one lane datum
  typedef logic [7:0] strb_t;
  // Word address into the vector register file
  typedef logic [11:0] vaddr_t;
  // Byte or element count of a vector
  typedef logic [15:0] vlen_t;
  // Instruction tag
  typedef logic [2:0] id_t;

  // Element width, also the shift from elements to bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vsew_e;

  // Defaults picked up by the top level
  localparam int unsigned DefLaneCount        = 4;
  localparam int unsigned DefInsnQueueDepth   = 2;
  localparam int unsigned DefResultQueueDepth = 2;

endpackage
